/* verilog.f */
logic/mem_map_pkg.sv
logic/bus_pkg.sv
logic/dbus_decoder.sv
logic/ram_bank.sv
logic/dbus_response_collector.sv
logic/dbus_fabric.sv
verif/dbus_fabric_sva.sv
verif/tb_dbus_fabric.sv

/* verif/tb_dbus_fabric.sv */
module tb_dbus_fabric;

    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 16;
    localparam int TABLE_LEN        = 20;
    localparam int RAND_PAIRS       = 64;
    localparam int MAPPED_LATENCY   = 4;
    localparam int UNMAPPED_LATENCY = 2;

    typedef struct packed {
        bus_pkg::cmd_op_e op;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [3:0]       be;
        logic [31:0]      exp_rdata;
        logic             exp_err;
    } vec_t;

    logic             w_clk;
    logic             rst_i;
    logic             cmd_valid;
    bus_pkg::cmd_op_e cmd_op;
    logic [31:0]      cmd_addr;
    logic [31:0]      cmd_wdata;
    logic [3:0]       cmd_be;
    logic             ack;
    logic             err;
    logic [31:0]      rdata;

    vec_t        vec_table [TABLE_LEN];
    logic [31:0] shadow [mem_map_pkg::NUM_BANKS][mem_map_pkg::BANK_WORDS];   // reference model
    logic [3:0]  shadow_known [mem_map_pkg::NUM_BANKS][mem_map_pkg::BANK_WORDS];

    int timing_errors = 0;
    int flag_errors   = 0;
    int data_errors   = 0;
    int seed          = 32'h9853;

    dbus_fabric dbus_fabric_inst (
        .w_clk       (w_clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid),
        .cmd_op_i    (cmd_op),
        .cmd_addr_i  (cmd_addr),
        .cmd_wdata_i (cmd_wdata),
        .cmd_be_i    (cmd_be),
        .ack_o       (ack),
        .err_o       (err),
        .rdata_o     (rdata)
    );

    initial begin
        w_clk = 1'b0;
        forever #(CLK_PERIOD / 2) w_clk = ~w_clk;
    end

    initial begin
        #((TABLE_LEN + 128) * 8 * CLK_PERIOD);
        $display("timeout: the run did not finish within the watchdog limit");
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] byte_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic update_shadow(input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic [3:0] be);
        int bank;
        int word;
        bank = addr[mem_map_pkg::BANK_SEL_MSB:mem_map_pkg::BANK_SEL_LSB];
        word = addr[mem_map_pkg::WORD_ADDR_MSB:mem_map_pkg::WORD_ADDR_LSB];
        shadow[bank][word] = (shadow[bank][word] & ~byte_mask(be)) | (wdata & byte_mask(be));
        shadow_known[bank][word] = shadow_known[bank][word] | be;
    endtask

    // drives one command and checks latency, err_o and masked read data
    task automatic run_command(input bus_pkg::cmd_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               input logic exp_err, input logic [31:0] exp_rdata,
                               input logic [31:0] rdata_mask);
        int   latency;
        int   exp_latency;
        logic done;
        exp_latency = exp_err ? UNMAPPED_LATENCY : MAPPED_LATENCY;
        latency     = 0;
        done        = 1'b0;
        @(posedge w_clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_wdata <= wdata;
        cmd_be    <= be;
        while (!done) begin
            @(posedge w_clk);
            cmd_valid <= 1'b0;              // one-cycle strobe
            latency++;
            @(negedge w_clk);
            if (ack === 1'b1) begin
                done = 1'b1;
            end else begin
                assert (err === 1'b0) else begin
                    flag_errors++;
                    $display("Fail time=%0t signal=err_o expected=0 actual=%b", $time, err);
                end
            end
        end
        assert (latency == exp_latency) else begin
            timing_errors++;
            $display("Fail time=%0t signal=ack_o latency expected=%0d actual=%0d",
                     $time, exp_latency, latency);
        end
        assert (err === exp_err) else begin
            flag_errors++;
            $display("Fail time=%0t signal=err_o expected=%b actual=%b", $time, exp_err, err);
        end
        if (op == bus_pkg::OP_READ && !exp_err) begin
            assert ((rdata & rdata_mask) === (exp_rdata & rdata_mask)) else begin
                data_errors++;
                $display("Fail time=%0t signal=rdata_o expected=%h actual=%h mask=%h",
                         $time, exp_rdata, rdata, rdata_mask);
            end
        end
        if (op == bus_pkg::OP_WRITE && !exp_err) begin
            update_shadow(addr, wdata, be);
        end
    endtask

    task automatic load_table();
        // same word offset in all four banks followed by partial writes and unmapped hits
        vec_table[0]  = '{bus_pkg::OP_WRITE, 32'h0000_0010, 32'h1111_1111, 4'hf, 32'h0, 1'b0};
        vec_table[1]  = '{bus_pkg::OP_WRITE, 32'h0000_1010, 32'h2222_2222, 4'hf, 32'h0, 1'b0};
        vec_table[2]  = '{bus_pkg::OP_WRITE, 32'h0000_2010, 32'h3333_3333, 4'hf, 32'h0, 1'b0};
        vec_table[3]  = '{bus_pkg::OP_WRITE, 32'h0000_3010, 32'h4444_4444, 4'hf, 32'h0, 1'b0};
        vec_table[4]  = '{bus_pkg::OP_READ,  32'h0000_0010, 32'h0, 4'hf, 32'h1111_1111, 1'b0};
        vec_table[5]  = '{bus_pkg::OP_READ,  32'h0000_1010, 32'h0, 4'hf, 32'h2222_2222, 1'b0};
        vec_table[6]  = '{bus_pkg::OP_READ,  32'h0000_2010, 32'h0, 4'hf, 32'h3333_3333, 1'b0};
        vec_table[7]  = '{bus_pkg::OP_READ,  32'h0000_3010, 32'h0, 4'hf, 32'h4444_4444, 1'b0};
        vec_table[8]  = '{bus_pkg::OP_WRITE, 32'h0000_1010, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0};
        vec_table[9]  = '{bus_pkg::OP_READ,  32'h0000_1010, 32'h0, 4'hf, 32'h22BB_22DD, 1'b0};
        vec_table[10] = '{bus_pkg::OP_WRITE, 32'h0000_2010, 32'hAABB_CCDD, 4'h8, 32'h0, 1'b0};
        vec_table[11] = '{bus_pkg::OP_READ,  32'h0000_2010, 32'h0, 4'hf, 32'hAA33_3333, 1'b0};
        vec_table[12] = '{bus_pkg::OP_WRITE, 32'h1000_0010, 32'hDEAD_BEEF, 4'hf, 32'h0, 1'b1};
        vec_table[13] = '{bus_pkg::OP_READ,  32'h8000_3010, 32'h0, 4'hf, 32'h0, 1'b1};
        vec_table[14] = '{bus_pkg::OP_READ,  32'h0000_0010, 32'h0, 4'hf, 32'h1111_1111, 1'b0};
        vec_table[15] = '{bus_pkg::OP_READ,  32'h0000_3010, 32'h0, 4'hf, 32'h4444_4444, 1'b0};
        vec_table[16] = '{bus_pkg::OP_WRITE, 32'h0000_3FFC, 32'h5A5A_5A5A, 4'hf, 32'h0, 1'b0};
        vec_table[17] = '{bus_pkg::OP_READ,  32'h0000_3FFC, 32'h0, 4'hf, 32'h5A5A_5A5A, 1'b0};
        vec_table[18] = '{bus_pkg::OP_WRITE, 32'hF000_0010, 32'h0BAD_F00D, 4'hf, 32'h0, 1'b1};
        vec_table[19] = '{bus_pkg::OP_READ,  32'h0000_0010, 32'h0, 4'hf, 32'h1111_1111, 1'b0};
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        logic [31:0] raddr;
        logic [31:0] rwdata;
        logic [3:0]  rbe;
        int          bank;
        int          word;
        int          sva_errors;
        rst_i     <= 1'b1;
        cmd_valid <= 1'b0;
        cmd_op    <= bus_pkg::OP_READ;
        cmd_addr  <= '0;
        cmd_wdata <= '0;
        cmd_be    <= '0;
        load_table();
        for (int b = 0; b < mem_map_pkg::NUM_BANKS; b++) begin
            for (int w = 0; w < mem_map_pkg::BANK_WORDS; w++) begin
                shadow_known[b][w] = 4'h0;  // bank contents start undefined
            end
        end
        repeat (RESET_CYCLES) begin
            @(negedge w_clk);
            assert (ack === 1'b0 && err === 1'b0) else begin
                flag_errors++;
                $display("Fail time=%0t signal=ack_o/err_o expected=0/0 actual=%b/%b",
                         $time, ack, err);
            end
        end
        @(posedge w_clk);
        rst_i <= 1'b0;

        for (int i = 0; i < TABLE_LEN; i++) begin
            run_command(vec_table[i].op, vec_table[i].addr, vec_table[i].wdata,
                        vec_table[i].be, vec_table[i].exp_err, vec_table[i].exp_rdata,
                        32'hFFFF_FFFF);
        end

        // random write/read pairs inside the ram region
        for (int i = 0; i < RAND_PAIRS; i++) begin
            raddr  = $random(seed);
            raddr  = {mem_map_pkg::REGION_RAM, raddr[27:2], 2'b00};
            rwdata = $random(seed);
            rbe    = $random(seed);
            bank   = raddr[mem_map_pkg::BANK_SEL_MSB:mem_map_pkg::BANK_SEL_LSB];
            word   = raddr[mem_map_pkg::WORD_ADDR_MSB:mem_map_pkg::WORD_ADDR_LSB];
            run_command(bus_pkg::OP_WRITE, raddr, rwdata, rbe, 1'b0, 32'h0, 32'h0);
            run_command(bus_pkg::OP_READ, raddr, 32'h0, 4'hf, 1'b0, shadow[bank][word],
                        byte_mask(shadow_known[bank][word]));
        end

        sva_errors = dbus_fabric_inst.dbus_fabric_sva_inst.assert_errors;
        $display("timing errors=%0d err_o errors=%0d rdata errors=%0d assertion errors=%0d",
                 timing_errors, flag_errors, data_errors, sva_errors);
        if (timing_errors + flag_errors + data_errors + sva_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verif/dbus_fabric_sva.sv */
module dbus_fabric_sva (
    input logic w_clk,
    input logic rst_i,
    input logic cmd_valid_i,
    input logic ack_i,
    input logic err_i
);

    logic outstanding;  // a command is waiting for its ack
    int   assert_errors = 0;

    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            outstanding <= 1'b0;
        end else if (cmd_valid_i) begin
            outstanding <= 1'b1;
        end else if (ack_i) begin
            outstanding <= 1'b0;
        end
    end

    // ------------------------------
    // handshake rules
    // ------------------------------
    ack_one_cycle: assert property (@(posedge w_clk) disable iff (rst_i) ack_i |=> !ack_i)
        else begin
            assert_errors++;
            $error("ack_o stayed high for two cycles");
        end

    err_needs_ack: assert property (@(posedge w_clk) disable iff (rst_i) err_i |-> ack_i)
        else begin
            assert_errors++;
            $error("err_o high without ack_o");
        end

    single_outstanding: assert property (@(posedge w_clk) disable iff (rst_i)
        cmd_valid_i |-> !outstanding)
        else begin
            assert_errors++;
            $error("cmd_valid_i raised while a command was outstanding");
        end

    ack_in_time: assert property (@(posedge w_clk) disable iff (rst_i)
        cmd_valid_i |-> ##[1:4] ack_i)
        else begin
            assert_errors++;
            $error("no ack_o within four cycles of cmd_valid_i");
        end

endmodule

bind dbus_fabric dbus_fabric_sva dbus_fabric_sva_inst (
    .w_clk       (w_clk),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .ack_i       (ack_o),
    .err_i       (err_o)
);

/* logic/dbus_fabric.sv */
module dbus_fabric (
    input  logic                       w_clk,
    input  logic                       rst_i,
    input  logic                       cmd_valid_i,
    input  bus_pkg::cmd_op_e           cmd_op_i,
    input  logic [bus_pkg::ADDR_W-1:0] cmd_addr_i,
    input  logic [bus_pkg::DATA_W-1:0] cmd_wdata_i,
    input  logic [bus_pkg::BE_W-1:0]   cmd_be_i,
    output logic                       ack_o,
    output logic                       err_o,
    output logic [bus_pkg::DATA_W-1:0] rdata_o
);

    // ------------------------------
    // decoder to banks
    // ------------------------------
    logic [mem_map_pkg::NUM_BANKS-1:0]   bank_valid;
    bus_pkg::cmd_op_e                    bank_op;
    logic [mem_map_pkg::WORD_ADDR_W-1:0] bank_word_addr;
    logic [bus_pkg::DATA_W-1:0]          bank_wdata;
    logic [bus_pkg::BE_W-1:0]            bank_be;
    logic                                unmapped;

    // banks to collector
    logic [mem_map_pkg::NUM_BANKS-1:0]                     bank_ack;
    logic [mem_map_pkg::NUM_BANKS-1:0][bus_pkg::DATA_W-1:0] bank_rdata;

    dbus_decoder dbus_decoder_inst (
        .w_clk            (w_clk),
        .rst_i            (rst_i),
        .cmd_valid_i      (cmd_valid_i),
        .cmd_op_i         (cmd_op_i),
        .cmd_addr_i       (cmd_addr_i),
        .cmd_wdata_i      (cmd_wdata_i),
        .cmd_be_i         (cmd_be_i),
        .bank_valid_o     (bank_valid),
        .bank_op_o        (bank_op),
        .bank_word_addr_o (bank_word_addr),
        .bank_wdata_o     (bank_wdata),
        .bank_be_o        (bank_be),
        .unmapped_o       (unmapped)
    );

    // ------------------------------
    // ram banks
    // ------------------------------
    for (genvar g = 0; g < mem_map_pkg::NUM_BANKS; g++) begin : g_bank
        ram_bank ram_bank_inst (
            .w_clk       (w_clk),
            .rst_i       (rst_i),
            .valid_i     (bank_valid[g]),     // own strobe
            .op_i        (bank_op),           // rest is shared
            .word_addr_i (bank_word_addr),
            .wdata_i     (bank_wdata),
            .be_i        (bank_be),
            .ack_o       (bank_ack[g]),
            .rdata_o     (bank_rdata[g])
        );
    end

    dbus_response_collector dbus_response_collector_inst (
        .w_clk        (w_clk),
        .rst_i        (rst_i),
        .bank_ack_i   (bank_ack),
        .bank_rdata_i (bank_rdata),
        .unmapped_i   (unmapped),
        .ack_o        (ack_o),
        .err_o        (err_o),
        .rdata_o      (rdata_o)
    );

endmodule

/* logic/dbus_response_collector.sv */
module dbus_response_collector (
    input  logic                                                  w_clk,
    input  logic                                                  rst_i,
    input  logic [mem_map_pkg::NUM_BANKS-1:0]                     bank_ack_i,
    input  logic [mem_map_pkg::NUM_BANKS-1:0][bus_pkg::DATA_W-1:0] bank_rdata_i,
    input  logic                                                  unmapped_i,
    output logic                                                  ack_o,
    output logic                                                  err_o,
    output logic [bus_pkg::DATA_W-1:0]                            rdata_o
);

    logic [bus_pkg::DATA_W-1:0] rdata_mux;

    // at most one bank acks, so an and-or mux is enough
    always_comb begin
        rdata_mux = '0;
        for (int i = 0; i < mem_map_pkg::NUM_BANKS; i++) begin
            if (bank_ack_i[i]) begin
                rdata_mux = rdata_mux | bank_rdata_i[i];
            end
        end
    end

    // ------------------------------
    // response register
    // ------------------------------
    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            ack_o <= (|bank_ack_i) || unmapped_i;
            err_o <= unmapped_i;                // only unmapped accesses fail
        end
    end

    always_ff @(posedge w_clk) begin
        if (|bank_ack_i) begin
            rdata_o <= rdata_mux;
        end else if (unmapped_i) begin
            rdata_o <= '0;                      // no data behind an error
        end
    end

endmodule

/* logic/ram_bank.sv */
module ram_bank (
    input  logic                                w_clk,
    input  logic                                rst_i,
    input  logic                                valid_i,
    input  bus_pkg::cmd_op_e                    op_i,
    input  logic [mem_map_pkg::WORD_ADDR_W-1:0] word_addr_i,
    input  logic [bus_pkg::DATA_W-1:0]          wdata_i,
    input  logic [bus_pkg::BE_W-1:0]            be_i,
    output logic                                ack_o,
    output logic [bus_pkg::DATA_W-1:0]          rdata_o
);

    logic [bus_pkg::DATA_W-1:0] mem [mem_map_pkg::BANK_WORDS];

    bus_pkg::bank_state_e state;

    logic [mem_map_pkg::WORD_ADDR_W-1:0] addr_q;
    logic [bus_pkg::DATA_W-1:0]          wdata_q;
    logic [bus_pkg::BE_W-1:0]            be_q;

    // ------------------------------
    // sequencer
    // ------------------------------
    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            state <= bus_pkg::BANK_IDLE;
        end else begin
            case (state)
                bus_pkg::BANK_IDLE: begin
                    if (valid_i) begin
                        state <= (op_i == bus_pkg::OP_WRITE) ? bus_pkg::BANK_WRITE
                                                             : bus_pkg::BANK_READ;
                    end
                end
                bus_pkg::BANK_WRITE: begin
                    state <= bus_pkg::BANK_ACK;
                end
                bus_pkg::BANK_READ: begin
                    state <= bus_pkg::BANK_ACK;
                end
                bus_pkg::BANK_ACK: begin
                    state <= bus_pkg::BANK_IDLE;    // ack lasts one cycle
                end
                default: begin
                    state <= bus_pkg::BANK_IDLE;
                end
            endcase
        end
    end

    // command latch taken only when idle
    always_ff @(posedge w_clk) begin
        if (state == bus_pkg::BANK_IDLE && valid_i) begin
            addr_q  <= word_addr_i;
            wdata_q <= wdata_i;
            be_q    <= be_i;
        end
    end

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge w_clk) begin
        if (state == bus_pkg::BANK_WRITE) begin
            for (int b = 0; b < bus_pkg::BE_W; b++) begin
                if (be_q[b]) begin
                    mem[addr_q][b*bus_pkg::BYTE_W +: bus_pkg::BYTE_W]
                        <= wdata_q[b*bus_pkg::BYTE_W +: bus_pkg::BYTE_W];
                end
            end
        end
        if (state == bus_pkg::BANK_READ) begin
            rdata_o <= mem[addr_q];     // held through the ack cycle
        end
    end

    assign ack_o = (state == bus_pkg::BANK_ACK);

endmodule

/* logic/dbus_decoder.sv */
module dbus_decoder (
    input  logic                                w_clk,
    input  logic                                rst_i,
    input  logic                                cmd_valid_i,
    input  bus_pkg::cmd_op_e                    cmd_op_i,
    input  logic [bus_pkg::ADDR_W-1:0]          cmd_addr_i,
    input  logic [bus_pkg::DATA_W-1:0]          cmd_wdata_i,
    input  logic [bus_pkg::BE_W-1:0]            cmd_be_i,
    output logic [mem_map_pkg::NUM_BANKS-1:0]   bank_valid_o,
    output bus_pkg::cmd_op_e                    bank_op_o,
    output logic [mem_map_pkg::WORD_ADDR_W-1:0] bank_word_addr_o,
    output logic [bus_pkg::DATA_W-1:0]          bank_wdata_o,
    output logic [bus_pkg::BE_W-1:0]            bank_be_o,
    output logic                                unmapped_o
);

    logic [mem_map_pkg::REGION_W-1:0]   region;
    logic                               ram_hit;
    logic [mem_map_pkg::BANK_SEL_W-1:0] bank_sel;
    logic [mem_map_pkg::NUM_BANKS-1:0]  bank_onehot;

    // ------------------------------
    // address decode
    // ------------------------------
    assign region   = cmd_addr_i[mem_map_pkg::REGION_MSB:mem_map_pkg::REGION_LSB];
    assign ram_hit  = (region == mem_map_pkg::REGION_RAM);
    assign bank_sel = cmd_addr_i[mem_map_pkg::BANK_SEL_MSB:mem_map_pkg::BANK_SEL_LSB];

    always_comb begin
        bank_onehot           = '0;
        bank_onehot[bank_sel] = 1'b1;   // one bank per command
    end

    // ------------------------------
    // strobes
    // ------------------------------
    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            bank_valid_o <= '0;
            unmapped_o   <= 1'b0;
        end else begin
            bank_valid_o <= (cmd_valid_i && ram_hit) ? bank_onehot : '0;
            unmapped_o   <= cmd_valid_i && !ram_hit;  // completes without a bank
        end
    end

    // payload shared by all banks
    always_ff @(posedge w_clk) begin
        if (cmd_valid_i) begin
            bank_op_o        <= cmd_op_i;
            bank_word_addr_o <= cmd_addr_i[mem_map_pkg::WORD_ADDR_MSB:mem_map_pkg::WORD_ADDR_LSB];
            bank_wdata_o     <= cmd_wdata_i;
            bank_be_o        <= cmd_be_i;
        end
    end

endmodule

/* logic/bus_pkg.sv */
package bus_pkg;

    // ------------------------------
    // data bus widths
    // ------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;                      // one enable per byte lane
    localparam int BYTE_W = DATA_W / BE_W;

    // command opcode as seen on the bus
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_e;

    // ram bank sequencer
    typedef enum logic [1:0] {
        BANK_IDLE  = 2'b00,
        BANK_WRITE = 2'b01,
        BANK_READ  = 2'b10,
        BANK_ACK   = 2'b11
    } bank_state_e;

endpackage

/* logic/mem_map_pkg.sv */
package mem_map_pkg;

    // ------------------------------
    // region decode
    // ------------------------------
    localparam int REGION_MSB = 31;                 // top nibble carries the region code
    localparam int REGION_LSB = 28;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    localparam logic [REGION_W-1:0] REGION_RAM = 4'h0;  // scratch ram is the only mapped region

    // ------------------------------
    // bank select
    // ------------------------------
    localparam int NUM_BANKS    = 4;
    localparam int BANK_SEL_MSB = 13;               // 4 KiB per bank
    localparam int BANK_SEL_LSB = 12;
    localparam int BANK_SEL_W   = BANK_SEL_MSB - BANK_SEL_LSB + 1;

    // ------------------------------
    // word within a bank
    // ------------------------------
    localparam int WORD_ADDR_MSB = 11;
    localparam int WORD_ADDR_LSB = 2;               // bits 1:0 are the byte lane
    localparam int WORD_ADDR_W   = WORD_ADDR_MSB - WORD_ADDR_LSB + 1;
    localparam int BANK_WORDS    = 1 << WORD_ADDR_W;  // 1024 words

    // Address bits 27:14 are not decoded inside the RAM region, so the
    // 16 KiB of banks alias throughout the lower 256 MiB.

endpackage
